/* rtl/fetchPkg.sv */
package fetchPkg;

  // lane count of one fetch bundle
  localparam int FETCH_WIDTH = 2;

  // pc and instruction widths
  localparam int SIZE_PC = 32;
  localparam int SIZE_INST = 32;

  // field widths inside a RISC-V instruction word
  localparam int SIZE_OPCODE = 7;
  localparam int SIZE_REG = 5;

  // byte distance between two sequential instructions
  localparam int INST_BYTES = 4;

  // return-address stack geometry
  localparam int RAS_DEPTH = 8;
  localparam int RAS_PTR_W = 3;

  // opcodes of the control transfer instructions
  localparam logic [SIZE_OPCODE-1:0] OP_JAL = 7'b1101111;
  localparam logic [SIZE_OPCODE-1:0] OP_JALR = 7'b1100111;
  localparam logic [SIZE_OPCODE-1:0] OP_BRANCH = 7'b1100011;

  // x0 and the link register x1 decide between call, return and plain jump
  localparam logic [SIZE_REG-1:0] REG_ZERO = 5'd0;
  localparam logic [SIZE_REG-1:0] REG_RA = 5'd1;

  // class of a control transfer as seen by the front end
  typedef enum logic [1:0] {
    JUMP_TYPE,
    CALL,
    RETURN,
    COND_BRANCH
  } ctrlType_t;

  // one lane coming out of fetch 1
  // takenPC is the target fetch 1 predicted, and also its next pc when predDir is set
  typedef struct packed {
    logic [SIZE_PC-1:0]   pc;
    logic [SIZE_INST-1:0] inst;
    logic                 valid;
    logic                 predDir;
    logic [SIZE_PC-1:0]   takenPC;
  } fs2Pkt;

  // a whole bundle, lane 0 is the oldest instruction
  typedef fs2Pkt [FETCH_WIDTH-1:0] fs2Bundle;

  // pre-decode result of one lane
  typedef struct packed {
    logic               ctrlInst;
    logic               condBranch;
    ctrlType_t          ctrlType;
    logic [SIZE_PC-1:0] predNPC;
  } ctrlInfo;

  // redirect request sent back to fetch 1
  typedef struct packed {
    logic               valid;
    logic [SIZE_PC-1:0] target;
  } redirectPkt;

endpackage

/* rtl/preDecode.sv */
module preDecode
  import fetchPkg::*;
(
  input  fs2Pkt              fs2Packet_i,
  input  logic [SIZE_PC-1:0] rasTop_i,
  output ctrlInfo            ctrl_o
);

  logic [SIZE_OPCODE-1:0] opcode;
  logic [SIZE_REG-1:0]    rd;
  logic [SIZE_REG-1:0]    rs1;
  logic [SIZE_PC-1:0]     immSB;
  logic [SIZE_PC-1:0]     immUJ;
  logic [SIZE_PC-1:0]     pcPlus4;
  logic [SIZE_PC-1:0]     predNPC;
  ctrlType_t              ctrlType;
  logic                   ctrlInst;

  // fixed RISC-V field positions
  assign opcode = fs2Packet_i.inst[SIZE_OPCODE-1:0];
  assign rd = fs2Packet_i.inst[11:7];
  assign rs1 = fs2Packet_i.inst[19:15];

  // branch offset, 13 bits with bit 0 always zero, sign taken from inst[31]
  assign immSB = {{(SIZE_PC-13){fs2Packet_i.inst[SIZE_INST-1]}},
                  fs2Packet_i.inst[SIZE_INST-1],
                  fs2Packet_i.inst[7],
                  fs2Packet_i.inst[30:25],
                  fs2Packet_i.inst[11:8],
                  1'b0};

  // jal offset, 21 bits, the scrambled order follows the UJ encoding
  assign immUJ = {{(SIZE_PC-21){fs2Packet_i.inst[SIZE_INST-1]}},
                  fs2Packet_i.inst[SIZE_INST-1],
                  fs2Packet_i.inst[19:12],
                  fs2Packet_i.inst[20],
                  fs2Packet_i.inst[30:21],
                  1'b0};

  assign pcPlus4 = fs2Packet_i.pc + SIZE_PC'(INST_BYTES);

  // a non-control lane simply falls through to the next sequential pc
  always_comb
  begin
    predNPC = pcPlus4;
    ctrlType = JUMP_TYPE;
    ctrlInst = 1'b0;
    case (opcode)
      OP_JAL:
      begin
        predNPC = fs2Packet_i.pc + immUJ;
        // jal has no rs1 field, so it is either a call or a plain jump
        ctrlType = (rd == REG_RA) ? CALL : JUMP_TYPE;
        ctrlInst = fs2Packet_i.valid;
      end
      OP_JALR:
      begin
        // register target is unknown here, so trust fetch 1 or the stack
        if (rd == REG_RA)
        begin
          ctrlType = CALL;
          predNPC = fs2Packet_i.takenPC;
        end
        else if ((rd == REG_ZERO) && (rs1 == REG_RA))
        begin
          ctrlType = RETURN;
          predNPC = rasTop_i;
        end
        else
        begin
          ctrlType = JUMP_TYPE;
          predNPC = fs2Packet_i.takenPC;
        end
        ctrlInst = fs2Packet_i.valid;
      end
      OP_BRANCH:
      begin
        // direction comes from fetch 1, only the taken target is recomputed
        predNPC = fs2Packet_i.predDir ? (fs2Packet_i.pc + immSB) : pcPlus4;
        ctrlType = COND_BRANCH;
        ctrlInst = fs2Packet_i.valid;
      end
      default:
      begin
        ctrlInst = 1'b0;
      end
    endcase
  end

  assign ctrl_o.ctrlInst = ctrlInst;
  assign ctrl_o.condBranch = (ctrlType == COND_BRANCH);
  assign ctrl_o.ctrlType = ctrlType;
  assign ctrl_o.predNPC = predNPC;

endmodule

/* rtl/returnAddrStack.sv */
module returnAddrStack
  import fetchPkg::*;
(
  input  logic               clk_i,
  input  logic               rstN_i,
  input  logic               push_i,
  input  logic               pop_i,
  input  logic [SIZE_PC-1:0] pushAddr_i,
  output logic [SIZE_PC-1:0] top_o
);

  // stack storage, indexed circularly
  logic [SIZE_PC-1:0]   stack [RAS_DEPTH];

  // points at the current top entry
  logic [RAS_PTR_W-1:0] topPtr;
  logic [RAS_PTR_W-1:0] nextPtr;
  logic [RAS_PTR_W-1:0] prevPtr;

  // the pointer wraps on its own, so overflow overwrites the oldest entry
  assign nextPtr = topPtr + RAS_PTR_W'(1);
  assign prevPtr = topPtr - RAS_PTR_W'(1);

  assign top_o = stack[topPtr];

  always_ff @(posedge clk_i)
  begin
    if (!rstN_i)
    begin
      topPtr <= '0;
      // a return seen before any call predicts address zero
      for (int i = 0; i < RAS_DEPTH; i++)
      begin
        stack[i] <= '0;
      end
    end
    else if (push_i && pop_i)
    begin
      // return and call in one step, the top is replaced in place
      stack[topPtr] <= pushAddr_i;
    end
    else if (push_i)
    begin
      stack[nextPtr] <= pushAddr_i;
      topPtr <= nextPtr;
    end
    else if (pop_i)
    begin
      // popping an empty stack just wraps round to the last slot
      topPtr <= prevPtr;
    end
  end

endmodule

/* rtl/fetchRedirect.sv */
module fetchRedirect
  import fetchPkg::*;
(
  input  fs2Bundle                     bundle_i,
  input  ctrlInfo [FETCH_WIDTH-1:0]    ctrl_i,
  input  logic                         bundleValid_i,
  output redirectPkt                   redirect_o,
  output logic [FETCH_WIDTH-1:0]       laneKeep_o,
  output logic                         rasPush_o,
  output logic                         rasPop_o,
  output logic [SIZE_PC-1:0]           rasPushAddr_o
);

  // state of the oldest control lane in the bundle
  logic               found;
  logic               offPath;
  ctrlInfo            firstCtrl;
  logic [SIZE_PC-1:0] firstPc;
  logic [SIZE_PC-1:0] assumedNPC;
  logic               mismatch;

  // lane 0 is oldest, so the first control lane found decides the path
  always_comb
  begin
    found = 1'b0;
    offPath = 1'b0;
    firstCtrl = '0;
    firstPc = '0;
    assumedNPC = '0;
    laneKeep_o = '1;
    for (int i = 0; i < FETCH_WIDTH; i++)
    begin
      if (found)
      begin
        // younger lanes only survive if the control lane falls through
        if (offPath)
        begin
          laneKeep_o[i] = 1'b0;
        end
      end
      else if (ctrl_i[i].ctrlInst)
      begin
        found = 1'b1;
        firstCtrl = ctrl_i[i];
        firstPc = bundle_i[i].pc;
        // fetch 1 went to takenPC if it predicted taken, else straight on
        if (bundle_i[i].predDir)
        begin
          assumedNPC = bundle_i[i].takenPC;
        end
        else
        begin
          assumedNPC = bundle_i[i].pc + SIZE_PC'(INST_BYTES);
        end
        offPath = (ctrl_i[i].predNPC != (bundle_i[i].pc + SIZE_PC'(INST_BYTES)));
      end
    end
  end

  // fetch 1 has to be steered when its guess differs from ours
  assign mismatch = found && (firstCtrl.predNPC != assumedNPC);

  assign redirect_o.valid = bundleValid_i && mismatch;
  assign redirect_o.target = firstCtrl.predNPC;

  // only the oldest control lane touches the stack
  assign rasPush_o = bundleValid_i && found && (firstCtrl.ctrlType == CALL);
  assign rasPop_o = bundleValid_i && found && (firstCtrl.ctrlType == RETURN);
  assign rasPushAddr_o = firstPc + SIZE_PC'(INST_BYTES);

endmodule

/* rtl/fetch2Stage.sv */
module fetch2Stage
  import fetchPkg::*;
(
  input  logic                       clk_i,
  input  logic                       rstN_i,
  input  fs2Bundle                   fs2Bundle_i,
  input  logic                       bundleValid_i,
  input  logic                       stall_i,
  output fs2Bundle                   outBundle_o,
  output ctrlInfo [FETCH_WIDTH-1:0]  outCtrl_o,
  output logic                       outValid_o,
  output redirectPkt                 redirect_o
);

  // stage register contents
  fs2Bundle                  stageBundle;
  logic                      stageValid;

  // per-lane pre-decode results
  ctrlInfo [FETCH_WIDTH-1:0] laneCtrl;
  logic [FETCH_WIDTH-1:0]    laneKeep;

  // stack interface
  logic [SIZE_PC-1:0]        rasTop;
  logic                      rasPush;
  logic                      rasPop;
  logic [SIZE_PC-1:0]        rasPushAddr;

  // valid bit of the stage register, it holds while stall_i is high
  always_ff @(posedge clk_i)
  begin
    if (!rstN_i)
    begin
      stageValid <= 1'b0;
    end
    else if (!stall_i)
    begin
      stageValid <= bundleValid_i;
    end
  end

  // the payload is only loaded when a bundle really enters
  always_ff @(posedge clk_i)
  begin
    if (!stall_i && bundleValid_i)
    begin
      stageBundle <= fs2Bundle_i;
    end
  end

  // one pre-decoder per lane, all of them see the same stack top
  for (genvar g = 0; g < FETCH_WIDTH; g++)
  begin : genLane
    preDecode laneDecode (
      .fs2Packet_i (stageBundle[g]),
      .rasTop_i    (rasTop),
      .ctrl_o      (laneCtrl[g])
    );
  end

  fetchRedirect redirectCheck (
    .bundle_i      (stageBundle),
    .ctrl_i        (laneCtrl),
    .bundleValid_i (stageValid),
    .redirect_o    (redirect_o),
    .laneKeep_o    (laneKeep),
    .rasPush_o     (rasPush),
    .rasPop_o      (rasPop),
    .rasPushAddr_o (rasPushAddr)
  );

  // stack moves only on the edge that hands this bundle on
  returnAddrStack ras (
    .clk_i      (clk_i),
    .rstN_i     (rstN_i),
    .push_i     (rasPush && !stall_i),
    .pop_i      (rasPop && !stall_i),
    .pushAddr_i (rasPushAddr),
    .top_o      (rasTop)
  );

  // squashed lanes leave with their valid bit cleared
  always_comb
  begin
    outBundle_o = stageBundle;
    for (int i = 0; i < FETCH_WIDTH; i++)
    begin
      outBundle_o[i].valid = stageBundle[i].valid && laneKeep[i];
    end
  end

  assign outCtrl_o = laneCtrl;
  assign outValid_o = stageValid;

endmodule

/* tests/fetch2_props.sv */
module fetch2_props
  import fetchPkg::*;
(
  input logic                      clk_i,
  input logic                      rstN_i,
  input logic                      stall_i,
  input logic                      bundleValid_i,
  input fs2Bundle                  fs2Bundle_i,
  input fs2Bundle                  outBundle_o,
  input ctrlInfo [FETCH_WIDTH-1:0] outCtrl_o,
  input logic                      outValid_o,
  input redirectPkt                redirect_o
);

  // reference stage register, loaded only by the accept rule at the inputs
  logic                 refValid;
  fs2Bundle             refBundle;
  // shadow copy of the return-address stack, kept from the decoded stream
  logic [SIZE_PC-1:0]   shadow [RAS_DEPTH];
  logic [RAS_PTR_W-1:0] sp;
  int                   failCount = 0;
  logic                 hasFirst;
  // two lanes, so one bit picks the first control lane
  logic                 firstIdx;
  logic [SIZE_PC-1:0]   expFirst;
  logic [SIZE_PC-1:0]   assumed;
  logic                 expRedirect;
  logic                 keepLane1;

  // a lane is a control transfer when it is valid and carries one of three opcodes
  function automatic logic isCtrl(fs2Pkt p);
    return p.valid && (p.inst[6:0] == OP_JAL || p.inst[6:0] == OP_JALR ||
                       p.inst[6:0] == OP_BRANCH);
  endfunction

  function automatic ctrlType_t classOf(fs2Pkt p);
    if (p.inst[6:0] == OP_BRANCH)
      return COND_BRANCH;
    if (p.inst[11:7] == REG_RA)
      return CALL;
    if (p.inst[6:0] == OP_JALR && p.inst[11:7] == REG_ZERO && p.inst[19:15] == REG_RA)
      return RETURN;
    return JUMP_TYPE;
  endfunction

  // next pc rebuilt from the encoding, with the shadow top standing in for a return
  function automatic logic [SIZE_PC-1:0] npcOf(fs2Pkt p, logic [SIZE_PC-1:0] top);
    logic signed [20:0] offUJ;
    logic signed [12:0] offSB;
    offUJ = {p.inst[31], p.inst[19:12], p.inst[20], p.inst[30:21], 1'b0};
    offSB = {p.inst[31], p.inst[7], p.inst[30:25], p.inst[11:8], 1'b0};
    if (p.inst[6:0] == OP_JAL)
      return p.pc + SIZE_PC'(offUJ);
    if (p.inst[6:0] == OP_BRANCH)
      return p.predDir ? p.pc + SIZE_PC'(offSB) : p.pc + 32'd4;
    return (classOf(p) == RETURN) ? top : p.takenPC;
  endfunction

  // a bundle enters on an edge with bundleValid_i high and stall_i low
  always_ff @(posedge clk_i)
  begin
    if (!rstN_i)
    begin
      refValid <= 1'b0;
    end
    else if (!stall_i)
    begin
      refValid <= bundleValid_i;
      if (bundleValid_i)
      begin
        refBundle <= fs2Bundle_i;
      end
    end
  end

  always_comb
  begin
    hasFirst = 1'b0;
    firstIdx = 1'b0;
    for (int i = 0; i < FETCH_WIDTH; i++)
    begin
      if (!hasFirst && isCtrl(refBundle[i]))
      begin
        hasFirst = 1'b1;
        firstIdx = 1'(i);
      end
    end
    expFirst = npcOf(refBundle[firstIdx], shadow[sp]);
    assumed = refBundle[firstIdx].predDir ? refBundle[firstIdx].takenPC :
              refBundle[firstIdx].pc + 32'd4;
    expRedirect = hasFirst && (expFirst != assumed);
    // lane 1 only loses its place behind a lane 0 that leaves the sequential path
    keepLane1 = !(hasFirst && firstIdx == 1'b0 && expFirst != refBundle[0].pc + 32'd4);
  end

  always_ff @(posedge clk_i)
  begin
    if (!rstN_i)
    begin
      sp <= '0;
      for (int i = 0; i < RAS_DEPTH; i++)
        shadow[i] <= '0;
    end
    else if (refValid && !stall_i && hasFirst)
    begin
      if (classOf(refBundle[firstIdx]) == CALL)
      begin
        shadow[sp + RAS_PTR_W'(1)] <= refBundle[firstIdx].pc + 32'd4;
        sp <= sp + RAS_PTR_W'(1);
      end
      else if (classOf(refBundle[firstIdx]) == RETURN)
        sp <= sp - RAS_PTR_W'(1);
    end
  end

  idleLow: assert property (@(posedge clk_i) disable iff (!rstN_i)
    outValid_o == refValid && (refValid || !redirect_o.valid))
    else
    begin
      failCount++;
      $error("ERR t=%0t outValid_o/redirect_o.valid got %b/%b exp %b/0", $time,
             outValid_o, redirect_o.valid, refValid);
    end

  for (genvar g = 0; g < FETCH_WIDTH; g++)
  begin : genLaneChk
    laneNpc: assert property (@(posedge clk_i) disable iff (!rstN_i)
      (refValid && isCtrl(refBundle[g])) |->
      (outCtrl_o[g].predNPC == npcOf(refBundle[g], shadow[sp]) &&
       outCtrl_o[g].ctrlType == classOf(refBundle[g]) &&
       outCtrl_o[g].condBranch == (refBundle[g].inst[6:0] == OP_BRANCH)))
      else
      begin
        failCount++;
        $error("ERR t=%0t outCtrl_o[%0d] got %h/%0d/%b exp %h/%0d/%b", $time, g,
               outCtrl_o[g].predNPC, outCtrl_o[g].ctrlType, outCtrl_o[g].condBranch,
               npcOf(refBundle[g], shadow[sp]), classOf(refBundle[g]),
               refBundle[g].inst[6:0] == OP_BRANCH);
      end

    laneCtrl: assert property (@(posedge clk_i) disable iff (!rstN_i)
      refValid |-> outCtrl_o[g].ctrlInst == isCtrl(refBundle[g]))
      else
      begin
        failCount++;
        $error("ERR t=%0t outCtrl_o[%0d].ctrlInst got %b exp %b", $time, g,
               outCtrl_o[g].ctrlInst, isCtrl(refBundle[g]));
      end

    // the payload leaves exactly as it was accepted one edge earlier
    laneData: assert property (@(posedge clk_i) disable iff (!rstN_i)
      refValid |-> (outBundle_o[g].pc == refBundle[g].pc &&
                    outBundle_o[g].inst == refBundle[g].inst &&
                    outBundle_o[g].predDir == refBundle[g].predDir &&
                    outBundle_o[g].takenPC == refBundle[g].takenPC))
      else
      begin
        failCount++;
        $error("ERR t=%0t outBundle_o[%0d] pc/inst got %h/%h exp %h/%h", $time, g,
               outBundle_o[g].pc, outBundle_o[g].inst, refBundle[g].pc, refBundle[g].inst);
      end
  end

  redirectChk: assert property (@(posedge clk_i) disable iff (!rstN_i)
    refValid |-> (redirect_o.valid == expRedirect &&
                  (!expRedirect || redirect_o.target == expFirst)))
    else
    begin
      failCount++;
      $error("ERR t=%0t redirect_o got %b/%h exp %b/%h", $time,
             redirect_o.valid, redirect_o.target, expRedirect, expFirst);
    end

  squashChk: assert property (@(posedge clk_i) disable iff (!rstN_i)
    refValid |-> (outBundle_o[0].valid == refBundle[0].valid &&
                  outBundle_o[1].valid == (refBundle[1].valid && keepLane1)))
    else
    begin
      failCount++;
      $error("ERR t=%0t outBundle_o lane valid got %b/%b exp %b/%b", $time,
             outBundle_o[0].valid, outBundle_o[1].valid,
             refBundle[0].valid, refBundle[1].valid && keepLane1);
    end

  returnChk: assert property (@(posedge clk_i) disable iff (!rstN_i)
    (refValid && hasFirst && classOf(refBundle[firstIdx]) == RETURN) |->
    outCtrl_o[firstIdx].predNPC == shadow[sp])
    else
    begin
      failCount++;
      $error("ERR t=%0t return predNPC got %h exp %h", $time,
             outCtrl_o[firstIdx].predNPC, shadow[sp]);
    end

  stallHold: assert property (@(posedge clk_i) disable iff (!rstN_i)
    stall_i |=> ($stable(outBundle_o) && $stable(outCtrl_o) && $stable(outValid_o)))
    else
    begin
      failCount++;
      $error("outputs changed while stall_i was high at time %0t", $time);
    end

endmodule

/* tests/fetch2Tb.sv */
module fetch2Tb
  import fetchPkg::*;
();

  logic                      clk_i = 1'b0;
  logic                      rstN_i;
  fs2Bundle                  fs2Bundle_i;
  logic                      bundleValid_i;
  logic                      stall_i;
  fs2Bundle                  outBundle_o;
  ctrlInfo [FETCH_WIDTH-1:0] outCtrl_o;
  logic                      outValid_o;
  redirectPkt                redirect_o;
  int                        timeoutErrs = 0;

  fetch2Stage UUT (
    .clk_i         (clk_i),
    .rstN_i        (rstN_i),
    .fs2Bundle_i   (fs2Bundle_i),
    .bundleValid_i (bundleValid_i),
    .stall_i       (stall_i),
    .outBundle_o   (outBundle_o),
    .outCtrl_o     (outCtrl_o),
    .outValid_o    (outValid_o),
    .redirect_o    (redirect_o)
  );

  bind fetch2Stage fetch2_props props (
    .clk_i         (clk_i),
    .rstN_i        (rstN_i),
    .stall_i       (stall_i),
    .bundleValid_i (bundleValid_i),
    .fs2Bundle_i   (fs2Bundle_i),
    .outBundle_o   (outBundle_o),
    .outCtrl_o     (outCtrl_o),
    .outValid_o    (outValid_o),
    .redirect_o    (redirect_o)
  );

  always #50 clk_i = ~clk_i;

  // register numbers lean on x0 and x1 so calls and returns turn up often
  function automatic logic [4:0] pickReg();
    int sel;
    sel = $urandom_range(0, 2);
    return (sel == 0) ? REG_ZERO : (sel == 1) ? REG_RA : 5'($urandom);
  endfunction

  function automatic logic [SIZE_INST-1:0] makeInst(logic [6:0] op, logic [4:0] rd,
                                                   logic [4:0] rs1);
    return {12'($urandom), rs1, 3'($urandom), rd, op};
  endfunction

  // lane 1 always follows lane 0 in memory
  function automatic fs2Bundle makeBundle(logic [SIZE_INST-1:0] inst0,
                                          logic [SIZE_INST-1:0] inst1);
    fs2Bundle b;
    b[0].pc = {30'($urandom_range(0, 32'h3fff_ffff)), 2'b00};
    b[1].pc = b[0].pc + 32'd4;
    b[0].inst = inst0;
    b[1].inst = inst1;
    for (int i = 0; i < FETCH_WIDTH; i++)
    begin
      b[i].valid = ($urandom_range(0, 7) != 0);
      b[i].predDir = $urandom_range(0, 1) == 1;
      b[i].takenPC = {30'($urandom_range(0, 32'h3fff_ffff)), 2'b00};
    end
    return b;
  endfunction

  function automatic logic [SIZE_INST-1:0] randInst();
    case ($urandom_range(0, 4))
      0: return makeInst(OP_JAL, pickReg(), pickReg());
      1: return makeInst(OP_JALR, pickReg(), pickReg());
      2: return makeInst(OP_BRANCH, pickReg(), pickReg());
      default: return makeInst(7'h13, pickReg(), pickReg());
    endcase
  endfunction

  // holds the bundle on the inputs until an edge with stall low takes it
  task automatic sendBundle(fs2Bundle b, int stallPct);
    int n;
    @(posedge clk_i);
    #10;
    fs2Bundle_i = b;
    bundleValid_i = 1'b1;
    stall_i = ($urandom_range(0, 99) < stallPct);
    n = 0;
    while (stall_i && n < 20)
    begin
      @(posedge clk_i);
      #10;
      stall_i = ($urandom_range(0, 99) < stallPct);
      n++;
    end
    if (stall_i)
    begin
      timeoutErrs++;
      $display("timeout: stall never released at time %0t", $time);
    end
  endtask

  task automatic waitOutValid();
    int n;
    n = 0;
    while (!outValid_o && n < 20)
    begin
      @(posedge clk_i);
      #10;
      n++;
    end
    if (!outValid_o)
    begin
      timeoutErrs++;
      $display("timeout: output bundle never became valid at time %0t", $time);
    end
  endtask

  initial
  begin
    fs2Bundle f;
    void'($urandom(66432));
    rstN_i = 1'b0;
    bundleValid_i = 1'b0;
    stall_i = 1'b0;
    fs2Bundle_i = '0;
    repeat (5) @(posedge clk_i);
    #10;
    rstN_i = 1'b1;
    repeat (3) @(posedge clk_i);
    // directed call then return, both in lane 0
    for (int k = 0; k < 6; k++)
    begin
      f = makeBundle(makeInst(OP_JAL, REG_RA, 5'd0), randInst());
      f[0].valid = 1'b1;
      sendBundle(f, 0);
      if (k == 0)
        waitOutValid();
      f = makeBundle(makeInst(OP_JALR, REG_ZERO, REG_RA), randInst());
      f[0].valid = 1'b1;
      sendBundle(f, 30);
    end
    for (int k = 0; k < 400; k++)
    begin
      sendBundle(makeBundle(randInst(), randInst()), 25);
      bundleValid_i = ($urandom_range(0, 4) != 0);
    end
    @(posedge clk_i);
    #10;
    bundleValid_i = 1'b0;
    stall_i = 1'b0;
    repeat (3) @(posedge clk_i);
    $display("errors: assertion %0d, timeout %0d", UUT.props.failCount, timeoutErrs);
    if (UUT.props.failCount == 0 && timeoutErrs == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  // last resort against a stuck run
  initial
  begin
    #2000000;
    $display("run stopped by the global time limit");
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* vlog.f */
rtl/fetchPkg.sv
rtl/preDecode.sv
rtl/returnAddrStack.sv
rtl/fetchRedirect.sv
rtl/fetch2Stage.sv
tests/fetch2_props.sv
tests/fetch2Tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = fetch2Tb
FILELIST  = vlog.f
OBJDIR    = obj_dir
RUNFLAGS  = +verilator+error+limit+1000
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG) || ! grep -q "Result: PASSED" $(LOG); then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
